// ==== Bender.yml ====
package:
  name: ppu_bg

sources:
  # Packages first
  - ppu_bg_pkg.sv
  - ppu_reg_pkg.sv
  # Pipeline blocks
  - bg_tile_latch.sv
  - bg_pixel_shifter.sv
  - bg_line_ctrl.sv
  - bg_palette_out.sv
  # Top level
  - ppu_bg_top.sv
  # Testbench
  - target: simulation
    files:
      - tb_ppu_bg.sv

// ==== bg_line_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module bg_line_ctrl(
	input  logic clkpipe,
	input  logic reset,
	input  logic line_start,
	input  logic [ppu_bg_pkg::FINE_W-1:0] scx_fine,
	input  logic row_ready,
	output logic fetch_req,
	output logic row_take,
	output logic load,
	output logic shift,
	output logic emit,
	output logic line_end
);
	import ppu_bg_pkg::*;

	localparam int CNT_W = $clog2(TILE_W + 1);
	localparam int ROW_W = $clog2(LINE_PIXELS / TILE_W + 2);

	logic active;
	logic start_pend;
	logic [CNT_W-1:0] pix_left;
	logic [FINE_W-1:0] discard_left;
	logic [X_W-1:0] emit_cnt;
	logic [ROW_W-1:0] rows_left;
	logic [ROW_W-1:0] rows_needed;

	// Rows covering the discarded pixels plus one visible line
	assign rows_needed = ROW_W'((LINE_PIXELS + TILE_W - 1 + scx_fine) / TILE_W);

	assign load      = active && (pix_left == '0) && row_ready;
	assign row_take  = load;
	assign shift     = active && (pix_left != '0); // Stalls once the planes run dry
	assign emit      = shift && (discard_left == '0);
	assign line_end  = emit && (emit_cnt == X_W'(LINE_PIXELS - 1));
	assign fetch_req = start_pend || (load && (rows_left != '0)); // Latch is free again

	always_ff @(posedge clkpipe) begin
		if (reset) begin
			active     <= 1'b0;
			start_pend <= 1'b0;
		end else if (line_start) begin
			active     <= 1'b1;
			start_pend <= 1'b1;
		end else begin
			start_pend <= 1'b0;
			if (line_end)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clkpipe) begin
		if (reset)
			pix_left <= '0;
		else if (line_start)
			pix_left <= '0;
		else if (load)
			pix_left <= CNT_W'(TILE_W);
		else if (shift)
			pix_left <= pix_left - 1'b1;
	end

	always_ff @(posedge clkpipe) begin
		if (reset)
			discard_left <= '0;
		else if (line_start)
			discard_left <= scx_fine; // Fine scroll sampled once per line
		else if (shift && (discard_left != '0))
			discard_left <= discard_left - 1'b1;
	end

	always_ff @(posedge clkpipe) begin
		if (reset)
			emit_cnt <= '0;
		else if (line_start)
			emit_cnt <= '0;
		else if (emit)
			emit_cnt <= emit_cnt + 1'b1;
	end

	always_ff @(posedge clkpipe) begin
		if (reset)
			rows_left <= '0;
		else if (line_start)
			rows_left <= rows_needed;
		else if (fetch_req)
			rows_left <= rows_left - 1'b1;
	end

endmodule

// ==== bg_palette_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module bg_palette_out(
	input  logic clkpipe,
	input  logic reset,
	input  logic bgp_wr,
	input  ppu_reg_pkg::bg_palette_t bgp_data,
	input  ppu_bg_pkg::bg_pix_t pix,
	input  logic emit,
	input  logic line_start,
	input  logic line_end,
	output logic pixel_valid,
	output ppu_reg_pkg::shade_t pixel_shade,
	output logic [ppu_bg_pkg::X_W-1:0] pixel_x,
	output logic line_done
);
	import ppu_bg_pkg::*;
	import ppu_reg_pkg::*;

	bg_palette_t bgp;
	logic [X_W-1:0] x_cnt;

	always_ff @(posedge clkpipe) begin
		if (reset)
			bgp <= '0;
		else if (bgp_wr)
			bgp <= bgp_data; // Seen by emits from the next cycle on
	end

	always_ff @(posedge clkpipe) begin
		if (reset) begin
			pixel_valid <= 1'b0;
			line_done   <= 1'b0;
		end else begin
			pixel_valid <= emit;
			line_done   <= line_end; // Lines up with the last pixel_valid
		end
	end

	always_ff @(posedge clkpipe) begin
		if (reset)
			x_cnt <= '0;
		else if (line_start)
			x_cnt <= '0;
		else if (emit)
			x_cnt <= x_cnt + 1'b1;
	end

	always_ff @(posedge clkpipe) begin
		if (emit) begin
			pixel_shade <= bgp_shade(bgp, pix);
			pixel_x     <= x_cnt;
		end
	end

endmodule

// ==== bg_pixel_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bg_pixel_shifter(
	input  logic clkpipe,
	input  logic reset,
	input  logic load,
	input  logic shift,
	input  ppu_bg_pkg::bg_tile_row_t row,
	output ppu_bg_pkg::bg_pix_t pix
);
	import ppu_bg_pkg::*;

	logic [TILE_W-1:0] plane_hi;
	logic [TILE_W-1:0] plane_lo;

	always_ff @(posedge clkpipe) begin
		if (reset) begin
			plane_hi <= '0;
			plane_lo <= '0;
		end else if (load) begin
			plane_hi <= row.plane_hi;
			plane_lo <= row.plane_lo;
		end else if (shift) begin
			plane_hi <= {plane_hi[TILE_W-2:0], 1'b0}; // Zero fill from bit 0
			plane_lo <= {plane_lo[TILE_W-2:0], 1'b0};
		end
	end

	// Leftmost pixel sits in bit 7 of both planes
	assign pix.hi = plane_hi[TILE_W-1];
	assign pix.lo = plane_lo[TILE_W-1];

endmodule

// ==== bg_tile_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module bg_tile_latch(
	input  logic clkpipe,
	input  logic reset,
	input  logic [7:0] md,
	input  logic tile_lo_stb,
	input  logic tile_hi_stb,
	input  logic row_take,
	output ppu_bg_pkg::bg_tile_row_t row,
	output logic row_ready
);
	import ppu_bg_pkg::*;

	logic [TILE_W-1:0] lo_hold;

	always_ff @(posedge clkpipe) begin
		if (tile_lo_stb)
			lo_hold <= md; // Frees md for the high plane
	end

	always_ff @(posedge clkpipe) begin
		if (tile_hi_stb) begin
			row.plane_hi <= md;
			row.plane_lo <= lo_hold;
		end
	end

	always_ff @(posedge clkpipe) begin
		if (reset)
			row_ready <= 1'b0;
		else if (tile_hi_stb)
			row_ready <= 1'b1;
		else if (row_take)
			row_ready <= 1'b0; // Row moved into the shifter
	end

endmodule

// ==== ppu_bg_pkg.sv ====
package ppu_bg_pkg;

	// One tile row as fetched from video memory
	typedef struct packed {
		logic [7:0] plane_hi;
		logic [7:0] plane_lo;
	} bg_tile_row_t;

	// Colour index of one pixel
	typedef struct packed {
		logic hi;
		logic lo;
	} bg_pix_t;

	localparam int TILE_W      = 8;   // Pixels per tile row
	localparam int LINE_PIXELS = 160; // Visible pixels per line
	localparam int X_W         = 8;   // Width of the x counter
	localparam int FINE_W      = 3;   // Width of the fine scroll

endpackage

// ==== ppu_bg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ppu_bg_top(
	input  logic clkpipe,
	input  logic reset,
	input  logic [7:0] md,
	input  logic tile_lo_stb,
	input  logic tile_hi_stb,
	input  logic line_start,
	input  logic [ppu_bg_pkg::FINE_W-1:0] scx_fine,
	input  logic bgp_wr,
	input  ppu_reg_pkg::bg_palette_t bgp_data,
	output logic fetch_req,
	output logic pixel_valid,
	output ppu_reg_pkg::shade_t pixel_shade,
	output logic [ppu_bg_pkg::X_W-1:0] pixel_x,
	output logic line_done
);

	ppu_bg_pkg::bg_tile_row_t row;
	ppu_bg_pkg::bg_pix_t pix;
	logic row_ready;
	logic row_take;
	logic load;
	logic shift;
	logic emit;
	logic line_end;

	bg_tile_latch i_bg_tile_latch (
		.clkpipe     (clkpipe),
		.reset       (reset),
		.md          (md),
		.tile_lo_stb (tile_lo_stb),
		.tile_hi_stb (tile_hi_stb),
		.row_take    (row_take),
		.row         (row),
		.row_ready   (row_ready)
	);

	bg_line_ctrl i_bg_line_ctrl (
		.clkpipe    (clkpipe),
		.reset      (reset),
		.line_start (line_start),
		.scx_fine   (scx_fine),
		.row_ready  (row_ready),
		.fetch_req  (fetch_req),
		.row_take   (row_take),
		.load       (load),
		.shift      (shift),
		.emit       (emit),
		.line_end   (line_end)
	);

	bg_pixel_shifter i_bg_pixel_shifter (
		.clkpipe (clkpipe),
		.reset   (reset),
		.load    (load),
		.shift   (shift),
		.row     (row),
		.pix     (pix)
	);

	bg_palette_out i_bg_palette_out (
		.clkpipe     (clkpipe),
		.reset       (reset),
		.bgp_wr      (bgp_wr),
		.bgp_data    (bgp_data),
		.pix         (pix),
		.emit        (emit),
		.line_start  (line_start),
		.line_end    (line_end),
		.pixel_valid (pixel_valid),
		.pixel_shade (pixel_shade),
		.pixel_x     (pixel_x),
		.line_done   (line_done)
	);

endmodule

// ==== ppu_reg_pkg.sv ====
package ppu_reg_pkg;

	typedef logic [1:0] shade_t; // 0 lightest, 3 darkest

	// BGP register layout with index 3 in the top bits
	typedef struct packed {
		shade_t shade3;
		shade_t shade2;
		shade_t shade1;
		shade_t shade0;
	} bg_palette_t;

	function automatic shade_t bgp_shade(bg_palette_t pal, logic [1:0] idx);
		shade_t s;
		case (idx)
			2'd0: s = pal.shade0;
			2'd1: s = pal.shade1;
			2'd2: s = pal.shade2;
			default: s = pal.shade3;
		endcase
		return s;
	endfunction

endpackage

// ==== tb_ppu_bg.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ppu_bg;
	import ppu_bg_pkg::*;
	import ppu_reg_pkg::*;

	localparam int FETCH_TIMEOUT = 300;  // Cycles to wait for one fetch_req
	localparam int LINE_TIMEOUT  = 4000; // Cycles to wait for a whole line
	localparam int MAX_ROWS      = 21;

	logic clkpipe;
	logic reset;
	logic [7:0] md;
	logic tile_lo_stb;
	logic tile_hi_stb;
	logic line_start;
	logic [FINE_W-1:0] scx_fine;
	logic bgp_wr;
	bg_palette_t bgp_data;
	logic fetch_req;
	logic pixel_valid;
	shade_t pixel_shade;
	logic [X_W-1:0] pixel_x;
	logic line_done;

	bg_tile_row_t rows [0:MAX_ROWS-1];
	bg_palette_t pal_model;      // Palette as the host last wrote it
	logic [1:0] exp_q [$];       // Expected shades of the current line
	logic [1:0] exp_shade;
	string test_name;
	int pix_cnt;
	int fetch_cnt;
	int fetch_limit;
	logic fetch_open;            // A fetch waits for its high byte

	ppu_bg_top i_ppu_bg_top (
		.clkpipe     (clkpipe),
		.reset       (reset),
		.md          (md),
		.tile_lo_stb (tile_lo_stb),
		.tile_hi_stb (tile_hi_stb),
		.line_start  (line_start),
		.scx_fine    (scx_fine),
		.bgp_wr      (bgp_wr),
		.bgp_data    (bgp_data),
		.fetch_req   (fetch_req),
		.pixel_valid (pixel_valid),
		.pixel_shade (pixel_shade),
		.pixel_x     (pixel_x),
		.line_done   (line_done)
	);

	initial begin
		clkpipe = 1'b0;
		forever #20 clkpipe = ~clkpipe;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			stop_on_error($sformatf("mismatch %s: expected %0d, actual %0d",
				name, expected, actual));
	endtask

	// Field idx of the register with shade0 in the low bits
	function automatic logic [1:0] shade_of(bg_palette_t pal, logic [1:0] idx);
		logic [7:0] raw;
		raw = pal;
		return raw[idx*2 +: 2];
	endfunction

	// Expand rows MSB first and keep one line of shades after the scroll pixels
	task automatic build_expected(input int scx, input int n_rows);
		int k;
		logic [1:0] idx;
		exp_q.delete();
		k = 0;
		for (int r = 0; r < n_rows; r++) begin
			for (int b = TILE_W - 1; b >= 0; b--) begin
				idx = {rows[r].plane_hi[b], rows[r].plane_lo[b]};
				if (k >= scx && k < scx + LINE_PIXELS)
					exp_q.push_back(shade_of(pal_model, idx));
				k++;
			end
		end
	endtask

	task automatic fill_known_rows();
		for (int i = 0; i < MAX_ROWS; i++) begin
			rows[i].plane_hi = 8'hF0 ^ 8'(i);
			rows[i].plane_lo = 8'hCC ^ 8'(i * 3);
		end
	endtask

	task automatic fill_random_rows();
		for (int i = 0; i < MAX_ROWS; i++)
			rows[i] = 16'($urandom());
	endtask

	task automatic write_palette(input bg_palette_t pal);
		@(negedge clkpipe);
		bgp_wr   = 1'b1;
		bgp_data = pal;
		@(negedge clkpipe);
		bgp_wr   = 1'b0;
		pal_model = pal;
	endtask

	task automatic wait_fetch();
		int n;
		n = 0;
		while (!fetch_req) begin
			if (n == FETCH_TIMEOUT)
				stop_on_error({"fetch_req never came in test ", test_name});
			@(negedge clkpipe);
			n++;
		end
	endtask

	// Host side of one fetch with the low plane first
	task automatic serve_row(input bg_tile_row_t r, input int max_delay);
		wait_fetch();
		repeat ($urandom_range(max_delay, 0)) @(negedge clkpipe);
		@(negedge clkpipe);
		md          = r.plane_lo;
		tile_lo_stb = 1'b1;
		@(negedge clkpipe);
		tile_lo_stb = 1'b0;
		repeat ($urandom_range(max_delay, 0)) @(negedge clkpipe);
		md          = r.plane_hi;
		tile_hi_stb = 1'b1;
		@(negedge clkpipe);
		tile_hi_stb = 1'b0;
		md          = 8'h00;
	endtask

	task automatic wait_line_done();
		int n;
		n = 0;
		while (pix_cnt < LINE_PIXELS) begin
			if (n == LINE_TIMEOUT)
				stop_on_error($sformatf("line never finished in test %s, %0d pixels seen",
					test_name, pix_cnt));
			@(negedge clkpipe);
			n++;
		end
	endtask

	task automatic run_line(input string name, input int scx, input int max_delay);
		int n_rows;
		n_rows = (scx + LINE_PIXELS + TILE_W - 1) / TILE_W;
		test_name = name;
		build_expected(scx, n_rows);
		pix_cnt     = 0;
		fetch_cnt   = 0;
		fetch_limit = n_rows;
		fetch_open  = 1'b0;
		@(negedge clkpipe);
		line_start = 1'b1;
		scx_fine   = FINE_W'(scx);
		@(negedge clkpipe);
		line_start = 1'b0;
		for (int i = 0; i < n_rows; i++)
			serve_row(rows[i], max_delay);
		wait_line_done();
		repeat (20) @(negedge clkpipe); // Room for stray pixels or fetches
	endtask

	task automatic test_pixel_order();
		fill_known_rows();
		write_palette(8'h93);
		run_line("pixel_order", 0, 0);
	endtask

	task automatic test_fine_scroll();
		for (int scx = 0; scx < TILE_W; scx++) begin
			fill_random_rows();
			run_line($sformatf("fine_scroll_%0d", scx), scx, 0);
		end
	endtask

	task automatic test_stall();
		fill_random_rows();
		run_line("stall_a", $urandom_range(7, 0), 5);
		fill_random_rows();
		run_line("stall_b", $urandom_range(7, 0), 9);
	endtask

	task automatic test_palette_update();
		fill_known_rows();
		write_palette(8'hE4);
		run_line("palette_old", 3, 0);
		write_palette(8'h1B); // Every field changes
		run_line("palette_new", 3, 0);
	endtask

	task automatic test_full_line();
		fill_random_rows();
		run_line("full_line", $urandom_range(7, 1), 2); // Needs all 21 rows
	endtask

	// Pixel collector
	always @(negedge clkpipe) begin
		if (!reset) begin
			if (line_done && !pixel_valid)
				stop_on_error({"line_done pulsed without pixel_valid in test ", test_name});
			if (pixel_valid) begin
				if (exp_q.size() == 0)
					stop_on_error({"pixel_valid with no pixel expected in test ", test_name});
				exp_shade = exp_q.pop_front();
				check_equal({test_name, " shade"}, exp_shade, pixel_shade);
				check_equal({test_name, " pixel_x"}, pix_cnt, pixel_x);
				check_equal({test_name, " line_done"}, pix_cnt == LINE_PIXELS - 1, line_done);
				pix_cnt++;
			end
		end
	end

	always @(posedge clkpipe) begin
		if (tile_hi_stb)
			fetch_open = 1'b0;
	end

	// Fetch monitor
	always @(negedge clkpipe) begin
		if (!reset && fetch_req) begin
			if (fetch_open)
				stop_on_error({"fetch_req came before the previous high byte in test ",
					test_name});
			if (fetch_cnt >= fetch_limit)
				stop_on_error({"fetch_req came after the last row of the line in test ",
					test_name});
			fetch_open = 1'b1;
			fetch_cnt++;
		end
	end

	initial begin
		void'($urandom(32'hc4d4));
		reset       = 1'b1;
		md          = 8'h00;
		tile_lo_stb = 1'b0;
		tile_hi_stb = 1'b0;
		line_start  = 1'b0;
		scx_fine    = '0;
		bgp_wr      = 1'b0;
		bgp_data    = '0;
		pal_model   = '0;
		test_name   = "reset";
		pix_cnt     = 0;
		fetch_cnt   = 0;
		fetch_limit = 0; // No fetch allowed before a line starts
		fetch_open  = 1'b0;
		repeat (8) @(negedge clkpipe);
		reset = 1'b0;
		check_equal("reset fetch_req", 0, fetch_req);
		check_equal("reset pixel_valid", 0, pixel_valid);
		check_equal("reset line_done", 0, line_done);
		repeat (4) @(negedge clkpipe);
		test_pixel_order();
		test_fine_scroll();
		test_stall();
		test_palette_update();
		test_full_line();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== vlog.f ====
ppu_bg_pkg.sv
ppu_reg_pkg.sv
bg_tile_latch.sv
bg_pixel_shifter.sv
bg_line_ctrl.sv
bg_palette_out.sv
ppu_bg_top.sv
tb_ppu_bg.sv
